// ==== logic/eth_mac_cfg.svh ====
`ifndef ETH_MAC_CFG_SVH
`define ETH_MAC_CFG_SVH

// Receive frame FIFO size in bytes, power of two and at least 64
`define ETH_FIFO_DEPTH 2048

// Idle cycles between transmitted frames
`define ETH_IFG_BYTES 12

// 0x55 bytes sent ahead of the SFD
`define ETH_PREAMBLE_BYTES 7

// CRC register value after a frame that carries its correct FCS
`define ETH_CRC_RESIDUE 32'hDEBB_20E3

`endif

// ==== logic/eth_frame_pkg.sv ====
package eth_frame_pkg;

    // Line bytes around the payload
    localparam logic [7:0] ETH_PRE_BYTE = 8'h55;
    localparam logic [7:0] ETH_SFD_BYTE = 8'hD5;

    // One byte of a stream, last marks the end of the frame
    typedef struct packed {
        logic [7:0] data;
        logic       last;
    } byte_beat_t;

    // End of frame report from the receive parser
    typedef struct packed {
        logic done;
        logic drop;
    } rx_status_t;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_PREAMBLE,
        RX_PAYLOAD
    } rx_state_t;

    typedef enum logic [2:0] {
        TX_IDLE,
        TX_PREAMBLE,
        TX_SFD,
        TX_DATA,
        TX_FCS,
        TX_GAP
    } tx_state_t;

endpackage

// ==== logic/eth_crc_pkg.sv ====
package eth_crc_pkg;

    typedef logic [31:0] crc32_t;

    // Reflected form of the 802.3 polynomial
    localparam crc32_t CRC32_POLY = 32'hEDB8_8320;

    // One byte through the CRC, LSB first as on the wire
    function automatic crc32_t crc32_byte(crc32_t crc, logic [7:0] data);
        crc32_t c;
        c = crc ^ {24'h0, data};
        for (int i = 0; i < 8; i++) begin
            if (c[0]) begin
                c = (c >> 1) ^ CRC32_POLY;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

endpackage

// ==== logic/eth_rx_parser.sv ====
`timescale 1ns/1ps

module eth_rx_parser import eth_frame_pkg::*; (
    input  logic       clk_125,
    input  logic       reset,
    input  logic [7:0] gmii_rxd,
    input  logic       gmii_rx_dv,
    input  logic       gmii_rx_er,
    output byte_beat_t par_beat,
    output logic       par_valid,
    output rx_status_t par_status,
    output logic       crc_en,
    output logic       crc_init
);

    rx_state_t       state;
    logic [2:0]      byte_cnt;
    logic            err_seen;
    logic [4:0][7:0] sr;

    // Checker follows these instead of looking for the SFD itself
    assign crc_init = (state == RX_PREAMBLE) && gmii_rx_dv && (gmii_rxd == ETH_SFD_BYTE);
    assign crc_en   = (state == RX_PAYLOAD) && gmii_rx_dv;

    always_ff @(posedge clk_125) begin
        if (reset) begin
            state      <= RX_IDLE;
            byte_cnt   <= '0;
            err_seen   <= 1'b0;
            par_valid  <= 1'b0;
            par_status <= '0;
        end else begin
            par_valid  <= 1'b0;
            par_status <= '0;
            case (state)
                RX_IDLE: begin
                    if (gmii_rx_dv && gmii_rxd == ETH_PRE_BYTE) begin
                        state    <= RX_PREAMBLE;
                        err_seen <= gmii_rx_er;
                    end
                end
                RX_PREAMBLE: begin
                    if (!gmii_rx_dv) begin
                        state <= RX_IDLE;
                    end else if (crc_init) begin
                        state    <= RX_PAYLOAD;
                        byte_cnt <= '0;
                    end
                    if (gmii_rx_er) begin
                        err_seen <= 1'b1;
                    end
                end
                RX_PAYLOAD: begin
                    if (gmii_rx_dv) begin
                        // Count saturates at the runt limit
                        if (byte_cnt < 3'd5) begin
                            byte_cnt <= byte_cnt + 3'd1;
                        end
                        if (gmii_rx_er) begin
                            err_seen <= 1'b1;
                        end
                        par_valid <= (byte_cnt == 3'd5);
                    end else begin
                        // Oldest held byte is the final payload byte
                        state           <= RX_IDLE;
                        par_valid       <= (byte_cnt == 3'd5);
                        par_status.done <= 1'b1;
                        par_status.drop <= (byte_cnt != 3'd5) || err_seen;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // Four bytes hold back the FCS, the fifth waits to learn if it is last
    always_ff @(posedge clk_125) begin
        if (crc_en) begin
            sr <= {sr[3:0], gmii_rxd};
        end
        if (state == RX_PAYLOAD) begin
            par_beat.data <= sr[4];
            par_beat.last <= !gmii_rx_dv;
        end
    end

endmodule

// ==== logic/eth_crc_check.sv ====
`timescale 1ns/1ps

`include "eth_mac_cfg.svh"

module eth_crc_check import eth_crc_pkg::*; (
    input  logic       clk_125,
    input  logic       reset,
    input  logic [7:0] gmii_rxd,
    input  logic       crc_en,
    input  logic       crc_init,
    output logic       crc_ok
);

    crc32_t crc;
    logic   crc_en_q;

    // Runs over payload and FCS together
    always_ff @(posedge clk_125) begin
        if (crc_init) begin
            crc <= '1;
        end else if (crc_en) begin
            crc <= crc32_byte(crc, gmii_rxd);
        end
    end

    // Result lands in the same cycle as the parser's done strobe
    always_ff @(posedge clk_125) begin
        if (reset) begin
            crc_en_q <= 1'b0;
            crc_ok   <= 1'b0;
        end else begin
            crc_en_q <= crc_en;
            crc_ok   <= crc_en_q && !crc_en && (crc == `ETH_CRC_RESIDUE);
        end
    end

endmodule

// ==== logic/eth_rx_fifo.sv ====
`timescale 1ns/1ps

`include "eth_mac_cfg.svh"

module eth_rx_fifo import eth_frame_pkg::*; (
    input  logic       clk_125,
    input  logic       reset,
    input  byte_beat_t par_beat,
    input  logic       par_valid,
    input  rx_status_t par_status,
    input  logic       crc_ok,
    output byte_beat_t rx_beat,
    output logic       rx_tvalid,
    input  logic       rx_tready
);

    localparam int DEPTH = `ETH_FIFO_DEPTH;
    localparam int AW    = $clog2(DEPTH);

    // One spare bit tells full from empty
    typedef logic [AW:0] ptr_t;

    byte_beat_t mem [DEPTH];

    ptr_t wr_tent;
    ptr_t wr_commit;
    ptr_t rd_ptr;
    ptr_t wr_next;
    logic ovf;
    logic full;
    logic empty;
    logic wr_en;
    logic wr_lost;
    logic keep;
    logic pop;

    // Space is judged against the tentative pointer
    assign full    = (wr_tent - rd_ptr) == ptr_t'(DEPTH);
    assign empty   = (rd_ptr == wr_commit);
    assign wr_en   = par_valid && !full && !ovf;
    assign wr_lost = par_valid && full;
    assign wr_next = wr_tent + ptr_t'(wr_en);
    assign keep    = crc_ok && !par_status.drop && !ovf && !wr_lost;
    assign pop     = !empty && (!rx_tvalid || rx_tready);

    always_ff @(posedge clk_125) begin
        if (wr_en) begin
            mem[wr_tent[AW-1:0]] <= par_beat;
        end
    end

    always_ff @(posedge clk_125) begin
        if (reset) begin
            wr_tent   <= '0;
            wr_commit <= '0;
            ovf       <= 1'b0;
        end else if (par_status.done) begin
            // Last byte may arrive with done, so commit includes it
            ovf <= 1'b0;
            if (keep) begin
                wr_tent   <= wr_next;
                wr_commit <= wr_next;
            end else begin
                wr_tent <= wr_commit;
            end
        end else begin
            wr_tent <= wr_next;
            if (wr_lost) begin
                ovf <= 1'b1;
            end
        end
    end

    // Output register, refilled whenever it empties or is taken
    always_ff @(posedge clk_125) begin
        if (reset) begin
            rd_ptr    <= '0;
            rx_tvalid <= 1'b0;
        end else if (pop) begin
            rd_ptr    <= rd_ptr + 1'b1;
            rx_tvalid <= 1'b1;
        end else if (rx_tready) begin
            rx_tvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk_125) begin
        if (pop) begin
            rx_beat <= mem[rd_ptr[AW-1:0]];
        end
    end

endmodule

// ==== logic/eth_tx_framer.sv ====
`timescale 1ns/1ps

`include "eth_mac_cfg.svh"

module eth_tx_framer import eth_frame_pkg::*, eth_crc_pkg::*; (
    input  logic       clk_125,
    input  logic       reset,
    input  byte_beat_t tx_beat,
    input  logic       tx_tvalid,
    output logic       tx_tready,
    output logic [7:0] gmii_txd,
    output logic       gmii_tx_en
);

    localparam logic [7:0] PRE_LAST = 8'(`ETH_PREAMBLE_BYTES - 1);
    localparam logic [7:0] GAP_LAST = 8'(`ETH_IFG_BYTES - 1);
    localparam logic [7:0] FCS_LAST = 8'd3;

    tx_state_t  state;
    logic [7:0] cnt;
    crc32_t     crc;
    logic       beat_ok;

    assign tx_tready = (state == TX_DATA);
    assign beat_ok   = tx_tready && tx_tvalid;

    // Counter is shared by preamble, FCS and gap
    always_ff @(posedge clk_125) begin
        if (reset) begin
            state      <= TX_IDLE;
            cnt        <= '0;
            gmii_tx_en <= 1'b0;
        end else begin
            case (state)
                TX_IDLE: begin
                    if (tx_tvalid) begin
                        state      <= TX_PREAMBLE;
                        gmii_tx_en <= 1'b1;
                        cnt        <= 8'd1;
                    end
                end
                TX_PREAMBLE: begin
                    cnt <= cnt + 8'd1;
                    if (cnt == PRE_LAST) begin
                        state <= TX_SFD;
                    end
                end
                TX_SFD: state <= TX_DATA;
                TX_DATA: begin
                    if (beat_ok && tx_beat.last) begin
                        state <= TX_FCS;
                        cnt   <= '0;
                    end
                end
                TX_FCS: begin
                    cnt <= cnt + 8'd1;
                    if (cnt == FCS_LAST) begin
                        state <= TX_GAP;
                        cnt   <= '0;
                    end
                end
                TX_GAP: begin
                    gmii_tx_en <= 1'b0;
                    cnt        <= cnt + 8'd1;
                    if (cnt == GAP_LAST) begin
                        state <= TX_IDLE;
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    // Wire byte and running CRC
    always_ff @(posedge clk_125) begin
        case (state)
            TX_IDLE, TX_PREAMBLE: gmii_txd <= ETH_PRE_BYTE;
            TX_SFD: begin
                gmii_txd <= ETH_SFD_BYTE;
                crc      <= '1;
            end
            TX_DATA: begin
                if (beat_ok) begin
                    gmii_txd <= tx_beat.data;
                    crc      <= crc32_byte(crc, tx_beat.data);
                end
            end
            TX_FCS: begin
                // Inverted CRC, low byte first
                gmii_txd <= ~crc[7:0];
                crc      <= crc >> 8;
            end
            default: gmii_txd <= 8'h00;
        endcase
    end

endmodule

// ==== logic/ethernet_mac_fifo.sv ====
`timescale 1ns/1ps

module ethernet_mac_fifo import eth_frame_pkg::*; (
    input  logic       clk_125,
    input  logic       reset,
    // Transmit stream in, GMII bytes out
    input  byte_beat_t tx_beat,
    input  logic       tx_tvalid,
    output logic       tx_tready,
    output logic [7:0] gmii_txd,
    output logic       gmii_tx_en,
    // GMII bytes in, receive stream out
    input  logic [7:0] gmii_rxd,
    input  logic       gmii_rx_dv,
    input  logic       gmii_rx_er,
    output byte_beat_t rx_beat,
    output logic       rx_tvalid,
    input  logic       rx_tready
);

    byte_beat_t par_beat;
    logic       par_valid;
    rx_status_t par_status;
    logic       crc_en;
    logic       crc_init;
    logic       crc_ok;

    eth_rx_parser u_rx_parser (
        .clk_125    (clk_125),
        .reset      (reset),
        .gmii_rxd   (gmii_rxd),
        .gmii_rx_dv (gmii_rx_dv),
        .gmii_rx_er (gmii_rx_er),
        .par_beat   (par_beat),
        .par_valid  (par_valid),
        .par_status (par_status),
        .crc_en     (crc_en),
        .crc_init   (crc_init)
    );

    // Sees the raw bytes, parser says which ones count
    eth_crc_check u_crc_check (
        .clk_125  (clk_125),
        .reset    (reset),
        .gmii_rxd (gmii_rxd),
        .crc_en   (crc_en),
        .crc_init (crc_init),
        .crc_ok   (crc_ok)
    );

    eth_rx_fifo u_rx_fifo (
        .clk_125    (clk_125),
        .reset      (reset),
        .par_beat   (par_beat),
        .par_valid  (par_valid),
        .par_status (par_status),
        .crc_ok     (crc_ok),
        .rx_beat    (rx_beat),
        .rx_tvalid  (rx_tvalid),
        .rx_tready  (rx_tready)
    );

    eth_tx_framer u_tx_framer (
        .clk_125    (clk_125),
        .reset      (reset),
        .tx_beat    (tx_beat),
        .tx_tvalid  (tx_tvalid),
        .tx_tready  (tx_tready),
        .gmii_txd   (gmii_txd),
        .gmii_tx_en (gmii_tx_en)
    );

endmodule

// ==== test/eth_mac_checker.sv ====
`timescale 1ns/1ps

`include "eth_mac_cfg.svh"

module eth_mac_checker import eth_frame_pkg::*; (
    input  logic       clk_125,
    input  logic       reset,
    input  logic [7:0] gmii_txd,
    input  logic       gmii_tx_en,
    input  logic       tx_tready,
    input  byte_beat_t rx_beat,
    input  logic       rx_tvalid,
    input  logic       rx_tready
);

    // Expected traffic, filled by the testbench top
    logic [7:0] tx_bytes[$];
    int         tx_lens[$];
    logic [7:0] rx_bytes[$];
    int         rx_lens[$];
    bit         rx_opt[$];

    int errors    = 0;
    int tx_frames = 0;
    int rx_frames = 0;

    logic [7:0] tx_cur[$];
    logic [7:0] rx_cur[$];
    logic       tx_en_q;
    int         gap;

    function automatic bit same_bytes(logic [7:0] a[$], logic [7:0] b[$]);
        if (a.size() != b.size()) begin
            return 1'b0;
        end
        foreach (a[i]) begin
            if (a[i] !== b[i]) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    task automatic check_tx_frame();
        int         len;
        logic [7:0] want;
        tx_frames++;
        if (tx_lens.size() == 0) begin
            errors++;
            $display("error at %0t: transmit frame that was never sent", $time);
        end else begin
            len = tx_lens.pop_front();
            if (len != tx_cur.size()) begin
                errors++;
                $display("error at %0t: gmii_tx_en high for %0d cycles, expected %0d",
                         $time, tx_cur.size(), len);
            end
            for (int i = 0; i < len; i++) begin
                want = tx_bytes.pop_front();
                if (i < tx_cur.size() && tx_cur[i] !== want) begin
                    errors++;
                    $display("error at %0t: wire byte %0d is %h, expected %h",
                             $time, i, tx_cur[i], want);
                end
            end
        end
        tx_cur.delete();
    endtask

    // Frames marked optional may have been dropped by an overflow
    task automatic check_rx_frame();
        logic [7:0] want[$];
        int         len;
        bit         opt;
        bit         stop;
        stop = 1'b0;
        rx_frames++;
        while (!stop && rx_lens.size() > 0) begin
            len = rx_lens.pop_front();
            opt = rx_opt.pop_front();
            want.delete();
            repeat (len) want.push_back(rx_bytes.pop_front());
            if (same_bytes(want, rx_cur)) begin
                stop = 1'b1;
            end else if (!opt) begin
                errors++;
                $display("error at %0t: received frame of %0d bytes, expected %0d bytes %p",
                         $time, rx_cur.size(), len, want);
                stop = 1'b1;
            end
        end
        if (!stop) begin
            errors++;
            $display("error at %0t: received frame of %0d bytes was never sent",
                     $time, rx_cur.size());
        end
        rx_cur.delete();
    endtask

    // Outputs change on the rising edge, so look at them on the falling one
    always @(negedge clk_125) begin
        if (reset) begin
            tx_cur.delete();
            gap = `ETH_IFG_BYTES;
        end else if (gmii_tx_en) begin
            if (!tx_en_q && gap < `ETH_IFG_BYTES) begin
                errors++;
                $display("error at %0t: only %0d idle cycles before transmit frame", $time, gap);
            end
            tx_cur.push_back(gmii_txd);
        end else if (tx_en_q) begin
            check_tx_frame();
            gap = 1;
        end else begin
            gap++;
        end
        // Payload is taken only after preamble and SFD, never in the gap
        if (!reset && tx_tready && !(gmii_tx_en && tx_cur.size() > `ETH_PREAMBLE_BYTES)) begin
            errors++;
            $display("error at %0t: tx_tready high outside the payload phase", $time);
        end
        tx_en_q = reset ? 1'b0 : gmii_tx_en;
    end

    // A beat seen here transfers on the next rising edge
    always @(negedge clk_125) begin
        if (!reset && rx_tvalid && rx_tready) begin
            rx_cur.push_back(rx_beat.data);
            if (rx_beat.last) begin
                check_rx_frame();
            end
        end
    end

endmodule

// ==== test/ethernet_mac_top_tb.sv ====
`timescale 1ns/1ps

`include "eth_mac_cfg.svh"

module ethernet_mac_top_tb
    import eth_frame_pkg::*;
();

    localparam logic [31:0] SEED = 32'h9061_ec80;
    localparam int WAIT_LIMIT = 20000;

    // Receive frame kinds
    localparam int GOOD    = 0;
    localparam int BAD_FCS = 1;
    localparam int RX_ERR  = 2;
    localparam int RUNT    = 3;

    // rx_tready behaviour
    localparam int READY = 0;
    localparam int STALL = 1;
    localparam int HOLD  = 2;

    logic       clk_125;
    logic       reset;
    byte_beat_t tx_beat;
    logic       tx_tvalid;
    logic       tx_tready;
    logic [7:0] gmii_txd;
    logic       gmii_tx_en;
    logic [7:0] gmii_rxd;
    logic       gmii_rx_dv;
    logic       gmii_rx_er;
    byte_beat_t rx_beat;
    logic       rx_tvalid;
    logic       rx_tready;

    logic [31:0] rnd       = SEED;
    logic [31:0] stall_rnd = SEED;
    int          stall_mode = READY;
    int          timeouts   = 0;
    logic [7:0]  payload[$];

    ethernet_mac_fifo dut (.*);

    eth_mac_checker eth_mac_checker (.*);

    initial begin
        clk_125 = 1'b0;
        forever #2 clk_125 = ~clk_125;
    end

    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic int take_bits(int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            rnd = lfsr_next(rnd);
            v = (v << 1) | rnd[0];
        end
        return v;
    endfunction

    // Reference FCS, one bit at a time in wire order, inverted at the end
    function automatic logic [31:0] ref_fcs(logic [7:0] pl[$]);
        logic [31:0] c;
        logic        fb;
        c = '1;
        foreach (pl[i]) begin
            for (int b = 0; b < 8; b++) begin
                fb = c[0] ^ pl[i][b];
                c = c >> 1;
                if (fb) begin
                    c = c ^ 32'hEDB8_8320;
                end
            end
        end
        return ~c;
    endfunction

    task automatic next_cycle();
        @(posedge clk_125);
        #1;
    endtask

    task automatic make_payload(int len);
        payload.delete();
        repeat (len) payload.push_back(8'(take_bits(8)));
    endtask

    task automatic send_tx(int len);
        logic [31:0] fcs;
        int          tmo;
        make_payload(len);
        fcs = ref_fcs(payload);
        repeat (`ETH_PREAMBLE_BYTES) eth_mac_checker.tx_bytes.push_back(8'h55);
        eth_mac_checker.tx_bytes.push_back(8'hD5);
        foreach (payload[i]) eth_mac_checker.tx_bytes.push_back(payload[i]);
        for (int k = 0; k < 4; k++) eth_mac_checker.tx_bytes.push_back(fcs[8*k +: 8]);
        eth_mac_checker.tx_lens.push_back(`ETH_PREAMBLE_BYTES + 1 + len + 4);
        for (int i = 0; i < len && timeouts == 0; i++) begin
            tx_beat.data = payload[i];
            tx_beat.last = (i == len - 1);
            tx_tvalid    = 1'b1;
            tmo = 0;
            while (!tx_tready && tmo < 100) begin
                next_cycle();
                tmo++;
            end
            if (!tx_tready) begin
                $display("timeout: transmit side stopped accepting payload bytes");
                timeouts++;
            end
            next_cycle();
        end
    endtask

    // Runts carry no FCS, just the few bytes after the SFD
    task automatic send_rx(int len, int kind, bit opt);
        logic [31:0] fcs;
        logic [7:0]  wire_q[$];
        int          flip;
        int          er_at;
        make_payload(len);
        fcs = ref_fcs(payload);
        if (kind == BAD_FCS) begin
            flip = take_bits(5);
            fcs[flip] = ~fcs[flip];
        end
        wire_q = payload;
        if (kind != RUNT) begin
            for (int k = 0; k < 4; k++) wire_q.push_back(fcs[8*k +: 8]);
        end
        er_at = (kind == RX_ERR) ? take_bits(6) % wire_q.size() : -1;
        if (kind == GOOD) begin
            foreach (payload[i]) eth_mac_checker.rx_bytes.push_back(payload[i]);
            eth_mac_checker.rx_lens.push_back(len);
            eth_mac_checker.rx_opt.push_back(opt);
        end
        repeat (`ETH_PREAMBLE_BYTES) drive_rx(8'h55, 1'b0);
        drive_rx(8'hD5, 1'b0);
        foreach (wire_q[i]) drive_rx(wire_q[i], i == er_at);
        gmii_rx_dv = 1'b0;
        gmii_rx_er = 1'b0;
        repeat (`ETH_IFG_BYTES) next_cycle();
    endtask

    task automatic drive_rx(logic [7:0] b, logic er);
        gmii_rxd   = b;
        gmii_rx_dv = 1'b1;
        gmii_rx_er = er;
        next_cycle();
    endtask

    initial begin
        forever begin
            next_cycle();
            if (stall_mode == STALL) begin
                stall_rnd = lfsr_next(stall_rnd);
                rx_tready = stall_rnd[0];
            end else begin
                rx_tready = (stall_mode == READY);
            end
        end
    end

    initial begin
        int tmo;
        int kind;
        reset      = 1'b1;
        tx_beat    = '0;
        tx_tvalid  = 1'b0;
        gmii_rxd   = 8'h00;
        gmii_rx_dv = 1'b0;
        gmii_rx_er = 1'b0;
        rx_tready  = 1'b0;
        repeat (2) @(posedge clk_125);
        #1;
        reset = 1'b0;
        next_cycle();

        // Back to back transmit frames
        send_tx(1);
        send_tx(64);
        repeat (6) send_tx(take_bits(6) + 1);
        tx_tvalid = 1'b0;

        send_rx(1, GOOD, 1'b0);
        send_rx(64, GOOD, 1'b0);
        send_rx(17, GOOD, 1'b0);

        // Bad frames between good ones, output stalling at random
        stall_mode = STALL;
        send_rx(20, GOOD, 1'b0);
        send_rx(33, BAD_FCS, 1'b0);
        send_rx(7, GOOD, 1'b0);
        send_rx(40, RX_ERR, 1'b0);
        send_rx(1, GOOD, 1'b0);
        send_rx(4, RUNT, 1'b0);
        send_rx(64, GOOD, 1'b0);
        repeat (16) begin
            kind = take_bits(2);
            send_rx((kind == RUNT) ? take_bits(2) + 1 : take_bits(6) + 1, kind, 1'b0);
        end

        // More than a FIFO's worth with the output blocked
        stall_mode = HOLD;
        repeat (`ETH_FIFO_DEPTH / 64 + 8) send_rx(64, GOOD, 1'b1);
        stall_mode = READY;
        tmo = 0;
        while (rx_tvalid && tmo < WAIT_LIMIT) begin
            next_cycle();
            tmo++;
        end
        if (rx_tvalid) begin
            $display("timeout: receive FIFO did not drain after the burst");
            timeouts++;
        end
        stall_mode = STALL;
        repeat (3) send_rx(take_bits(6) + 1, GOOD, 1'b0);

        tmo = 0;
        while (eth_mac_checker.tx_lens.size() + eth_mac_checker.rx_lens.size() != 0 &&
               tmo < WAIT_LIMIT) begin
            next_cycle();
            tmo++;
        end
        if (tmo >= WAIT_LIMIT) begin
            $display("timeout: expected frames never came out of the DUT");
            timeouts++;
        end

        $display("errors=%0d timeouts=%0d tx_frames=%0d rx_frames=%0d",
                 eth_mac_checker.errors, timeouts,
                 eth_mac_checker.tx_frames, eth_mac_checker.rx_frames);
        if (timeouts != 0 || eth_mac_checker.errors != 0) begin
            $display("SIMULATION FAILED");
        end else begin
            $display("SIMULATION PASSED");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+logic
logic/eth_frame_pkg.sv
logic/eth_crc_pkg.sv
logic/eth_rx_parser.sv
logic/eth_crc_check.sv
logic/eth_rx_fifo.sv
logic/eth_tx_framer.sv
logic/ethernet_mac_fifo.sv
test/eth_mac_checker.sv
test/ethernet_mac_top_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= ethernet_mac_top_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard logic/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
